// ==== Bender.yml ====
package:
  name: div_unit

dependencies: {}

sources:
  # package first, then the blocks, then the top level.
  - files:
      - source/div_pkg.sv
      - source/div_issue.sv
      - source/div_lane.sv
      - source/div_writeback.sv
      - source/div_unit.sv

  # testbench, top module div_unit_tb.
  - target: test
    files:
      - test/div_checker.sv
      - test/div_unit_tb.sv

// ==== source/div_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_issue #(
   parameter int N_LANES = 2
)(
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  logic [N_LANES-1:0] lane_idle,
   output logic [N_LANES-1:0] lane_start,
   output logic               ready
);

   localparam int PW = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [PW-1:0] r_ptr;        // first lane to try.
   logic [PW-1:0] pick_idx;
   logic          found;
   int            idx;

   // scan from the pointer, wrapping around.
   always_comb
   begin
      found = 1'b0;
      pick_idx = r_ptr;
      idx = 0;
      for (int k = 0; k < N_LANES; k++)
      begin
         idx = (int'(r_ptr) + k) % N_LANES;
         if (!found && lane_idle[idx])
         begin
            found = 1'b1;
            pick_idx = PW'(idx);
         end
      end
   end

   always_comb
   begin
      lane_start = '0;
      if (start && found)
      begin
         lane_start[pick_idx] = 1'b1;
      end
   end

   assign ready = (|lane_idle) & ~start;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_ptr <= '0;
      end
      else if (start && found)
      begin
         r_ptr <= (pick_idx == PW'(N_LANES - 1)) ? '0 : pick_idx + 1'b1;  // step past pick.
      end
   end

   // the environment only starts after seeing ready.
   a_start_has_lane: assert property (@(posedge clk) disable iff (reset)
      start |-> |lane_idle);

endmodule

`default_nettype wire

// ==== source/div_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_lane #(
   parameter int LG_W = 6
)(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  div_pkg::div_req_t req,
   input  logic              grant,
   output logic              idle,
   output logic              done,
   output div_pkg::div_res_t res
);

   import div_pkg::*;

   localparam int W = 1 << LG_W;
   localparam int W2 = 2 * W;

   typedef enum logic [2:0]
   {
      st_idle,
      st_divide,
      st_pack,
      st_hold,
      st_cache_pack
   } state_t;

   // per-op context, captured at start.
   typedef struct packed
   {
      logic                      is_signed;
      logic                      is_rem;
      logic                      word;
      logic                      q_neg;
      logic                      r_neg;
      logic [LG_ROB_ENTRIES-1:0] rob_ptr;
      logic [LG_PRF_ENTRIES-1:0] prf_ptr;
   } ctx_t;

   // last completed op, raw magnitudes.
   typedef struct packed
   {
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic         is_signed;
      logic [W-1:0] q;
      logic [W-1:0] r;
   } cache_t;

   state_t        r_state, n_state;
   ctx_t          r_ctx;
   ctx_t          n_ctx;
   cache_t        r_cache;
   logic          r_cache_valid;
   logic [W-1:0]  r_a;          // dividend magnitude.
   logic [W-1:0]  r_b;          // divisor magnitude.
   logic [W2-1:0] r_rr;         // {partial remainder, dividend bits}.
   logic [W-1:0]  r_q;          // quotient shift register.
   logic [LG_W-1:0] r_cnt;
   logic [W-1:0]  r_y;

   logic [W-1:0]  ext_a, ext_b;
   logic [W-1:0]  mag_a, mag_b;
   logic          sgn;
   logic [W2-1:0] shifted;
   logic [W:0]    diff;
   logic          step_bit;
   logic [W2-1:0] step_rr;
   logic          hit;

   function automatic logic [W-1:0] word_ext(input logic [M_WIDTH-1:0] v, input logic s,
                                             input logic word);
      logic [M_WIDTH-1:0] e;
      e = v;
      if (word)
      begin
         e = s ? M_WIDTH'($signed(v[31:0])) : M_WIDTH'(v[31:0]);
      end
      return e[W-1:0];
   endfunction

   // sign fixes, quotient or remainder, word extension.
   function automatic logic [W-1:0] pack_result(input logic [W-1:0] q_mag,
                                                input logic [W-1:0] r_mag, input ctx_t c);
      logic [W-1:0] q;
      logic [W-1:0] r;
      logic [W-1:0] y;
      q = c.q_neg ? -q_mag : q_mag;
      r = c.r_neg ? -r_mag : r_mag;
      y = c.is_rem ? r : q;
      if (c.word)
      begin
         y = W'($signed(y[31:0]));
      end
      return y;
   endfunction

   assign sgn = op_is_signed(req.op);
   assign ext_a = word_ext(req.a, sgn, req.word);
   assign ext_b = word_ext(req.b, sgn, req.word);
   assign mag_a = (sgn && ext_a[W-1]) ? -ext_a : ext_a;
   assign mag_b = (sgn && ext_b[W-1]) ? -ext_b : ext_b;

   always_comb
   begin
      n_ctx.is_signed = sgn;
      n_ctx.is_rem = op_is_rem(req.op);
      n_ctx.word = req.word;
      n_ctx.q_neg = sgn & (ext_a[W-1] ^ ext_b[W-1]);
      n_ctx.r_neg = sgn & ext_a[W-1];
      n_ctx.rob_ptr = req.rob_ptr;
      n_ctx.prf_ptr = req.prf_ptr;
   end

   // one restoring step.
   assign shifted = {r_rr[W2-2:0], 1'b0};
   assign diff = {1'b0, shifted[W2-1:W]} - {1'b0, r_b};
   assign step_bit = ~diff[W];
   assign step_rr = step_bit ? {diff[W-1:0], shifted[W-1:0]} : shifted;

   assign hit = r_cache_valid && (r_cache.a == r_a) && (r_cache.b == r_b) &&
                (r_cache.is_signed == r_ctx.is_signed);

   always_comb
   begin
      n_state = r_state;
      case (r_state)
         st_idle:
         begin
            if (start)
            begin
               n_state = st_divide;
            end
         end
         st_divide:
         begin
            if ((&r_cnt) && hit)
            begin
               n_state = st_cache_pack;  // first cycle only.
            end
            else if (r_cnt == '0)
            begin
               n_state = st_pack;
            end
         end
         st_pack, st_cache_pack:
         begin
            n_state = st_hold;
         end
         st_hold:
         begin
            if (grant)
            begin
               n_state = st_idle;
            end
         end
         default:
         begin
            n_state = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= st_idle;
         r_cache_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         if (r_state == st_pack)
         begin
            r_cache_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      case (r_state)
         st_idle:
         begin
            if (start)
            begin
               r_ctx <= n_ctx;
               r_a <= mag_a;
               r_b <= mag_b;
               r_rr <= {{W{1'b0}}, mag_a};
               r_cnt <= '1;
            end
         end
         st_divide:
         begin
            r_rr <= step_rr;
            r_q <= {r_q[W-2:0], step_bit};
            r_cnt <= r_cnt - 1'b1;
         end
         st_pack:
         begin
            r_y <= pack_result(r_q, r_rr[W2-1:W], r_ctx);
            r_cache.a <= r_a;
            r_cache.b <= r_b;
            r_cache.is_signed <= r_ctx.is_signed;
            r_cache.q <= r_q;
            r_cache.r <= r_rr[W2-1:W];
         end
         st_cache_pack:
         begin
            r_y <= pack_result(r_cache.q, r_cache.r, r_ctx);  // signs from this op.
         end
         default:
         begin
         end
      endcase
   end

   assign idle = (r_state == st_idle);
   assign done = (r_state == st_hold);

   always_comb
   begin
      res.y = M_WIDTH'($signed(r_y));
      res.rob_ptr = r_ctx.rob_ptr;
      res.prf_ptr = r_ctx.prf_ptr;
   end

   a_grant_when_done: assert property (@(posedge clk) disable iff (reset)
      grant |-> done);

   a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
      start |-> idle);

endmodule

`default_nettype wire

// ==== source/div_pkg.sv ====
`default_nettype none

package div_pkg;

   localparam int M_WIDTH = 64;
   localparam int LG_ROB_ENTRIES = 6;
   localparam int LG_PRF_ENTRIES = 7;

   // signed ops are the even codes.
   typedef enum logic [1:0]
   {
      op_div  = 2'd0,
      op_divu = 2'd1,
      op_rem  = 2'd2,
      op_remu = 2'd3
   } div_op_t;

   typedef struct packed
   {
      logic [M_WIDTH-1:0]        a;        // dividend.
      logic [M_WIDTH-1:0]        b;        // divisor.
      div_op_t                   op;
      logic                      word;     // 32-bit op.
      logic [LG_ROB_ENTRIES-1:0] rob_ptr;
      logic [LG_PRF_ENTRIES-1:0] prf_ptr;
   } div_req_t;

   typedef struct packed
   {
      logic [M_WIDTH-1:0]        y;
      logic [LG_ROB_ENTRIES-1:0] rob_ptr;
      logic [LG_PRF_ENTRIES-1:0] prf_ptr;
   } div_res_t;

   function automatic logic op_is_signed(input div_op_t op);
      return (op == op_div) || (op == op_rem);
   endfunction

   function automatic logic op_is_rem(input div_op_t op);
      return (op == op_rem) || (op == op_remu);
   endfunction

endpackage

`default_nettype wire

// ==== source/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
   parameter int LG_W = 6,
   parameter int N_LANES = 2
)(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  div_pkg::div_req_t req,
   input  logic              wb_slot_used,
   output logic              ready,
   output logic              complete,
   output div_pkg::div_res_t res
);

   import div_pkg::*;

   logic     [N_LANES-1:0] lane_idle;
   logic     [N_LANES-1:0] lane_start;
   logic     [N_LANES-1:0] lane_done;
   logic     [N_LANES-1:0] lane_grant;
   div_res_t [N_LANES-1:0] lane_res;

   div_issue #(
      .N_LANES (N_LANES)
   ) u_issue (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .lane_idle  (lane_idle),
      .lane_start (lane_start),
      .ready      (ready)
   );

   // request is broadcast, only the strobed lane takes it.
   for (genvar i = 0; i < N_LANES; i++)
   begin : g_lane
      div_lane #(
         .LG_W (LG_W)
      ) u_lane (
         .clk   (clk),
         .reset (reset),
         .start (lane_start[i]),
         .req   (req),
         .grant (lane_grant[i]),
         .idle  (lane_idle[i]),
         .done  (lane_done[i]),
         .res   (lane_res[i])
      );
   end

   div_writeback #(
      .N_LANES (N_LANES)
   ) u_writeback (
      .clk          (clk),
      .reset        (reset),
      .lane_done    (lane_done),
      .lane_res     (lane_res),
      .wb_slot_used (wb_slot_used),
      .lane_grant   (lane_grant),
      .complete     (complete),
      .res          (res)
   );

endmodule

`default_nettype wire

// ==== source/div_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_writeback #(
   parameter int N_LANES = 2
)(
   input  logic                                clk,
   input  logic                                reset,
   input  logic              [N_LANES-1:0]     lane_done,
   input  div_pkg::div_res_t [N_LANES-1:0]     lane_res,
   input  logic                                wb_slot_used,
   output logic              [N_LANES-1:0]     lane_grant,
   output logic                                complete,
   output div_pkg::div_res_t                   res
);

   logic [N_LANES-1:0] r_prio;      // one-hot, highest priority lane.
   logic [N_LANES-1:0] eligible;
   logic [N_LANES-1:0] upper_mask;
   logic [N_LANES-1:0] masked;
   logic [N_LANES-1:0] pick_from;
   logic [N_LANES-1:0] next_prio;

   assign eligible = wb_slot_used ? '0 : lane_done;

   // lanes at or above the priority bit win first.
   assign upper_mask = ~(r_prio - 1'b1);
   assign masked = eligible & upper_mask;
   assign pick_from = (|masked) ? masked : eligible;
   assign lane_grant = pick_from & (~pick_from + 1'b1);  // lowest set bit.

   assign complete = |lane_grant;

   always_comb
   begin
      res = '0;
      for (int i = 0; i < N_LANES; i++)
      begin
         if (lane_grant[i])
         begin
            res = lane_res[i];
         end
      end
   end

   // rotate left by one past the winner.
   assign next_prio = N_LANES'(lane_grant << 1) | N_LANES'(lane_grant >> (N_LANES - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_prio <= N_LANES'(1);
      end
      else if (complete)
      begin
         r_prio <= next_prio;
      end
   end

   // the priority pointer must survive every rotation.
   a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(lane_grant) && $onehot(r_prio));

endmodule

`default_nettype wire

// ==== tb.f ====
source/div_pkg.sv
source/div_issue.sv
source/div_lane.sv
source/div_writeback.sv
source/div_unit.sv
test/div_checker.sv
test/div_unit_tb.sv

// ==== test/div_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_checker #(
   parameter int LG_W = 6,
   parameter int N_LANES = 2
)(
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  div_pkg::div_req_t req,
   input  logic              wb_slot_used,
   input  logic              ready,
   input  logic              complete,
   input  div_pkg::div_res_t res,
   input  logic              expect_hit,
   output int                error_count,
   output int                open_count
);

   import div_pkg::*;

   localparam int W = 1 << LG_W;
   localparam int N_TAGS = 1 << LG_ROB_ENTRIES;
   localparam int MAX_AGE = 1000;   // cycles a result may stay outstanding.
   localparam int HIT_CYCLES = 3;   // capture, match, cache pack.

   logic [M_WIDTH-1:0]        exp_y [N_TAGS];
   logic [LG_PRF_ENTRIES-1:0] exp_prf [N_TAGS];
   logic                      pending [N_TAGS];
   int                        age [N_TAGS];
   int                        stalls [N_TAGS];   // cycles lost to the slot or other lanes.
   int                        exp_lat [N_TAGS];  // start to complete, cycles.
   int                        compared;
   int                        tag;
   int                        t;
   logic                      first_cycle;
   logic                      exp_ready;

   function automatic logic [M_WIDTH-1:0] sext32(input logic [M_WIDTH-1:0] v);
      return {{32{v[31]}}, v[31:0]};
   endfunction

   function automatic logic [M_WIDTH-1:0] model_y(input div_req_t r);
      logic               sgn;
      logic [M_WIDTH-1:0] a, b, ma, mb, q, rm, y;
      sgn = (r.op == op_div) || (r.op == op_rem);
      a = r.a;
      b = r.b;
      if (r.word)
      begin
         a = sgn ? sext32(r.a) : {32'h0, r.a[31:0]};
         b = sgn ? sext32(r.b) : {32'h0, r.b[31:0]};
      end
      ma = (sgn && a[63]) ? -a : a;
      mb = (sgn && b[63]) ? -b : b;
      if (mb == '0)
      begin
         q = '1;
         rm = ma;
      end
      else
      begin
         q = ma / mb;
         rm = ma % mb;
      end
      if (sgn && (a[63] ^ b[63]))
         q = -q;
      if (sgn && a[63])
         rm = -rm;
      y = ((r.op == op_rem) || (r.op == op_remu)) ? rm : q;
      return r.word ? sext32(y) : y;
   endfunction

   task report();
      $display("checker: %0d results compared, %0d errors, %0d still outstanding",
               compared, error_count, open_count);
   endtask

   task check_result();
      tag = res.rob_ptr;
      if (!pending[tag])
      begin
         $display("rob tag %0d completed at t=%0t but was not outstanding", tag, $time);
         error_count++;
      end
      else
      begin
         if (res.y !== exp_y[tag])
         begin
            $display("FAIL t=%0t res.y: got %h expected %h (rob %0d)", $time, res.y,
                     exp_y[tag], tag);
            error_count++;
         end
         if (res.prf_ptr !== exp_prf[tag])
         begin
            $display("FAIL t=%0t res.prf_ptr: got %0d expected %0d (rob %0d)", $time,
                     res.prf_ptr, exp_prf[tag], tag);
            error_count++;
         end
         if (age[tag] + 1 > exp_lat[tag] + stalls[tag])
         begin
            $display("rob tag %0d took %0d cycles with only %0d stalled, too slow",
                     tag, age[tag] + 1, stalls[tag]);
            error_count++;
         end
         pending[tag] = 1'b0;
         open_count--;
         compared++;
      end
   endtask

   // sample at the falling edge, where ports are settled.
   always @(negedge clk)
   begin
      if (reset)
      begin
         for (t = 0; t < N_TAGS; t++)
            pending[t] = 1'b0;
         error_count = 0;
         open_count = 0;
         compared = 0;
         first_cycle = 1'b1;
      end
      else
      begin
         if (first_cycle && complete)
         begin
            $display("complete was high in the first cycle after reset, t=%0t", $time);
            error_count++;
         end
         first_cycle = 1'b0;
         exp_ready = !start && (open_count < N_LANES);  // one lane per open result.
         if (ready !== exp_ready)
         begin
            $display("FAIL t=%0t ready: got %b expected %b", $time, ready, exp_ready);
            error_count++;
         end
         if (complete && wb_slot_used)
         begin
            $display("complete rose at t=%0t while the writeback slot was taken", $time);
            error_count++;
         end
         if (complete)
            check_result();
         for (t = 0; t < N_TAGS; t++)
         begin
            if (pending[t])
            begin
               age[t]++;
               if (wb_slot_used || (complete && res.rob_ptr != t))
                  stalls[t]++;
               if (age[t] > MAX_AGE)
               begin
                  $display("rob tag %0d outstanding for more than %0d cycles", t, MAX_AGE);
                  error_count++;
                  pending[t] = 1'b0;
                  open_count--;
               end
            end
         end
         if (start)
         begin
            tag = req.rob_ptr;
            if (pending[tag])
            begin
               $display("rob tag %0d reused at t=%0t while still outstanding", tag, $time);
               error_count++;
            end
            else
               open_count++;
            pending[tag] = 1'b1;
            exp_y[tag] = model_y(req);
            exp_prf[tag] = req.prf_ptr;
            exp_lat[tag] = expect_hit ? HIT_CYCLES : W + 2;
            age[tag] = 0;
            stalls[tag] = 0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

   import div_pkg::*;

   localparam int LG_W = 6;
   localparam int N_LANES = 2;
   localparam int W = 1 << LG_W;
   localparam int READY_TIMEOUT = 2000;
   localparam int DRAIN_TIMEOUT = 2000;

   logic     clk;
   logic     reset;
   logic     start;
   div_req_t req;
   logic     wb_slot_used;
   logic     ready;
   logic     complete;
   div_res_t res;

   int                        error_count;
   int                        open_count;
   integer                    seed;
   logic                      wb_random;   // randomize the shared slot each cycle.
   logic                      expect_hit;  // next op should hit a lane cache.
   logic [LG_ROB_ENTRIES-1:0] next_tag;
   logic [M_WIDTH-1:0]        corner_a [6];
   logic [M_WIDTH-1:0]        corner_b [6];

   always #5 clk = ~clk;

   div_unit #(
      .LG_W    (LG_W),
      .N_LANES (N_LANES)
   ) DUT (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .req          (req),
      .wb_slot_used (wb_slot_used),
      .ready        (ready),
      .complete     (complete),
      .res          (res)
   );

   div_checker #(
      .LG_W    (LG_W),
      .N_LANES (N_LANES)
   ) u_checker (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .req          (req),
      .wb_slot_used (wb_slot_used),
      .ready        (ready),
      .complete     (complete),
      .res          (res),
      .expect_hit   (expect_hit),
      .error_count  (error_count),
      .open_count   (open_count)
   );

   task automatic next_cycle();
      @(posedge clk);
      #1;
      if (wb_random)
         wb_slot_used = ({$random(seed)} % 10) < 3;  // about 30% taken.
   endtask

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      u_checker.report();
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic send_op(input logic [M_WIDTH-1:0] a, input logic [M_WIDTH-1:0] b,
                          input div_op_t op, input logic word);
      int waited;
      waited = 0;
      next_cycle();
      while (!ready)
      begin
         next_cycle();
         waited++;
         if (waited > READY_TIMEOUT)
            abort_run("ready stayed low too long");
      end
      req.a = a;
      req.b = b;
      req.op = op;
      req.word = word;
      req.rob_ptr = next_tag;
      req.prf_ptr = LG_PRF_ENTRIES'({$random(seed)});
      start = 1'b1;
      next_tag = next_tag + 1'b1;
      next_cycle();
      start = 1'b0;
   endtask

   task automatic send_random();
      logic [31:0]        r0, r1, r2, r3, sel;
      logic [M_WIDTH-1:0] a, b;
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      sel = $random(seed);
      a = {r0, r1};
      b = {r2, r3};
      if (sel[1:0] == 2'd0)
         b = b >> sel[7:2];  // small divisors, some zero.
      if (sel[1:0] == 2'd1)
         a = a >> sel[7:2];
      send_op(a, b, div_op_t'(sel[9:8]), sel[12:10] < 3'd3);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (open_count != 0)
      begin
         next_cycle();
         waited++;
         if (waited > DRAIN_TIMEOUT)
            abort_run("results still outstanding after the drain timeout");
      end
   endtask

   initial
   begin
      int i;
      int k;
      int waited;
      seed = 32'h25d3;
      clk = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      req = '0;
      wb_slot_used = 1'b0;
      wb_random = 1'b0;
      expect_hit = 1'b0;
      next_tag = '0;
      corner_a = '{64'h8000_0000_0000_0000, 64'h0123_4567_89ab_cdef, 64'h0,
                   64'hfedc_ba98_7654_3210, 64'hdead_beef_8000_0000, 64'hffff_ffff_ffff_fff9};
      corner_b = '{64'hffff_ffff_ffff_ffff, 64'h0, 64'h7,
                   64'hfedc_ba98_7654_3210, 64'h1234_5678_ffff_ffff, 64'h2};
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      wb_random = 1'b1;
      for (i = 0; i < 6; i++)
         for (k = 0; k < 8; k++)
            send_op(corner_a[i], corner_b[i], div_op_t'(k[1:0]), k[2]);
      repeat (200) send_random();
      wait_drain();
      // repeated operands with the slot free, later ones hit a lane cache.
      wb_random = 1'b0;
      wb_slot_used = 1'b0;
      for (i = 0; i < 4; i++)
      begin
         corner_a[0] = {$random(seed), $random(seed)};
         corner_b[0] = {16'h0, $random(seed), 16'h0};
         for (k = 0; k < 2 * N_LANES; k++)
         begin
            expect_hit = (k >= N_LANES);
            send_op(corner_a[0], corner_b[0], div_op_t'({k[0], i[0]}), i == 3);
         end
      end
      expect_hit = 1'b0;
      wait_drain();
      // fill every lane while the writeback slot is taken.
      wb_slot_used = 1'b1;
      for (k = 0; k < N_LANES; k++)
         send_random();
      waited = 0;
      while (ready)
      begin
         next_cycle();
         waited++;
         if (waited > READY_TIMEOUT)
            abort_run("ready did not drop with all lanes occupied");
      end
      repeat (2 * (W + 2)) next_cycle();
      wb_slot_used = 1'b0;
      wait_drain();
      u_checker.report();
      if (error_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
